// ==== tb.f ====
+incdir+hw
hw/ad9361_axis_pkg.sv
hw/ad9361_sample_packer.sv
hw/ad9361_stream_framer.sv
hw/ad9361_dual_axis_top.sv
sim/ad9361_axis_props.sv
sim/tb_ad9361_axis.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the AD9361 stream testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
  --top-module tb_ad9361_axis \
  -Mdir "$BUILD_DIR" -o tb_sim \
  -f tb.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$BUILD_DIR/tb_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^test passed$" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// ==== sim/tb_ad9361_axis.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the dual-channel raw sample to stream path
// DUT runs with PRECISION 10 and 16-beat bursts
// stimulus from $urandom with a fixed seed, stops at the first error
//////////////////////////////////////////////////////////////////////

`include "ad9361_axis_consts.svh"

module tb_ad9361_axis
  import ad9361_axis_pkg::*;
();

  localparam int PREC       = 10;
  localparam int BURST      = 16;
  localparam int RAW_W      = `AD_RAW_WIDTH;
  localparam int LANE_W     = `AD_LANE_WIDTH;
  localparam int NUM_LANES  = 2 * `AD_NUM_PAIRS;

  localparam int P1_STROBES = 64;
  localparam int P1_GAP     = 3;
  localparam int P3_STROBES = 48;
  localparam int P3_GAP     = 6;
  localparam int P4_STROBES = 8;
  localparam int DRAIN_LEN  = 8;

  // reset, idle check, three phases, stall release and drains
  localparam int STIM_CYCLES = 5 + 10 + P1_STROBES * P1_GAP + P3_STROBES * P3_GAP
                               + P4_STROBES + 5 + 3 * DRAIN_LEN;
  localparam int TIMEOUT     = 4 * STIM_CYCLES + 200;

  logic        m_axis_clk;
  logic        rst_n;
  logic        valid_0;
  logic        valid_1;
  logic        valid_2;
  logic        valid_3;
  raw_sample_t data_i0;
  raw_sample_t data_q0;
  raw_sample_t data_i1;
  raw_sample_t data_q1;
  raw_sample_t data_i2;
  raw_sample_t data_q2;
  raw_sample_t data_i3;
  raw_sample_t data_q3;
  logic        m_axis_tready;
  logic        m_axis_tvalid;
  logic        m_axis_tlast;
  axis_word_t  m_axis_tdata;
  logic        overflow;

  // 0 always ready, 1 random, 2 held low
  int          ready_mode;
  int          err_cnt;
  int unsigned cycle_cnt;

  // model state
  axis_word_t  exp_q [$];
  logic        mdl_valid;
  logic        mdl_strobe;
  axis_word_t  mdl_word;
  logic        mdl_ovf;
  int          mdl_cnt;
  int          mdl_drops;

  // observed on the DUT outputs
  int          beats_seen;
  int          lasts_seen;
  int          ovf_seen;
  int          beats_since_last;

  ad9361_dual_axis_top #(
    .PRECISION    (PREC),
    .REVERSE_DATA (0),
    .BURST_LEN    (BURST)
  ) DUT (
    .m_axis_clk    (m_axis_clk),
    .rst_n         (rst_n),
    .valid_0       (valid_0),
    .valid_1       (valid_1),
    .valid_2       (valid_2),
    .valid_3       (valid_3),
    .data_i0       (data_i0),
    .data_q0       (data_q0),
    .data_i1       (data_i1),
    .data_q1       (data_q1),
    .data_i2       (data_i2),
    .data_q2       (data_q2),
    .data_i3       (data_i3),
    .data_q3       (data_q3),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tdata  (m_axis_tdata),
    .overflow      (overflow)
  );

  initial begin
    m_axis_clk = 1'b0;
    forever #4 m_axis_clk = ~m_axis_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and compare tasks
  //////////////////////////////////////////////////////////////////////

  // i0 goes to the top lane, q3 to the bottom one
  function automatic axis_word_t pack_ref(input raw_sample_t i0, q0, i1, q1,
                                          input raw_sample_t i2, q2, i3, q3);
    raw_sample_t vals [NUM_LANES];
    axis_word_t  word;
    lane_t       lane;
    vals[0] = i0;
    vals[1] = q0;
    vals[2] = i1;
    vals[3] = q1;
    vals[4] = i2;
    vals[5] = q2;
    vals[6] = i3;
    vals[7] = q3;
    word = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      // extend first, then drop the low bits
      lane = lane_t'(vals[k]) >>> (RAW_W - PREC);
      word[(NUM_LANES - 1 - k) * LANE_W +: LANE_W] = lane;
    end
    return word;
  endfunction

  task automatic stop_on_error();
    err_cnt++;
    $display("test failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_word(input string name, input axis_word_t got, input axis_word_t exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAIL at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // scoreboard
  //////////////////////////////////////////////////////////////////////

  // outputs read at the edge are the values the edge acts on
  always @(posedge m_axis_clk) begin : scoreboard
    logic xfer;
    logic stall;
    logic any_valid;
    if (!rst_n) begin
      exp_q.delete();
      mdl_valid  = 1'b0;
      mdl_strobe = 1'b0;
      mdl_ovf    = 1'b0;
      mdl_cnt    = 0;
    end else begin
      xfer  = mdl_valid & m_axis_tready;
      stall = mdl_valid & ~m_axis_tready;
      check_bit("m_axis_tvalid", m_axis_tvalid, mdl_valid);
      check_bit("overflow", overflow, mdl_ovf);
      check_bit("m_axis_tlast", m_axis_tlast, mdl_valid & (mdl_cnt == BURST - 1));
      if (mdl_valid) begin
        check_word("m_axis_tdata", m_axis_tdata, exp_q[0]);
      end
      if (overflow) begin
        ovf_seen++;
      end
      if (m_axis_tvalid && m_axis_tready) begin
        beats_seen++;
        if (m_axis_tlast) begin
          lasts_seen++;
          beats_since_last = 0;
        end else begin
          beats_since_last++;
        end
      end
      if (xfer) begin
        void'(exp_q.pop_front());
        mdl_cnt = (mdl_cnt == BURST - 1) ? 0 : mdl_cnt + 1;
      end
      // a word reaching a stalled register is lost
      mdl_ovf = mdl_strobe & stall;
      if (mdl_strobe && stall) begin
        mdl_drops++;
      end
      if (mdl_strobe && !stall) begin
        exp_q.push_back(mdl_word);
        mdl_valid = 1'b1;
      end else if (xfer) begin
        mdl_valid = 1'b0;
      end
      any_valid  = valid_0 | valid_1 | valid_2 | valid_3;
      mdl_strobe = any_valid;
      if (any_valid) begin
        mdl_word = pack_ref(data_i0, data_q0, data_i1, data_q1,
                            data_i2, data_q2, data_i3, data_q3);
      end
    end
  end

  always @(posedge m_axis_clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      $display("timeout after %0d cycles, the stream stalled", cycle_cnt);
      stop_on_error();
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  function automatic raw_sample_t draw_sample(input int sel);
    case (sel)
      0:       return 12'sh800;
      1:       return 12'shfff;
      2:       return 12'sh7ff;
      // -3 must floor to -1
      3:       return 12'shffd;
      default: return raw_sample_t'($urandom());
    endcase
  endfunction

  // falling edge, new tready, strobes back low
  task automatic next_cycle();
    @(negedge m_axis_clk);
    case (ready_mode)
      0:       m_axis_tready = 1'b1;
      1:       m_axis_tready = 1'($urandom_range(1, 0));
      default: m_axis_tready = 1'b0;
    endcase
    valid_0 = 1'b0;
    valid_1 = 1'b0;
    valid_2 = 1'b0;
    valid_3 = 1'b0;
  endtask

  // one pair valid, all eight values fresh
  task automatic send_strobe(input bit corners, input int k);
    int which;
    which = $urandom_range(3, 0);
    case (which)
      0:       valid_0 = 1'b1;
      1:       valid_1 = 1'b1;
      2:       valid_2 = 1'b1;
      default: valid_3 = 1'b1;
    endcase
    data_i0 = draw_sample(corners ? (k + 0) % 4 : 4);
    data_q0 = draw_sample(corners ? (k + 1) % 4 : 4);
    data_i1 = draw_sample(corners ? (k + 2) % 4 : 4);
    data_q1 = draw_sample(corners ? (k + 3) % 4 : 4);
    data_i2 = draw_sample(corners ? (k + 1) % 4 : 4);
    data_q2 = draw_sample(corners ? (k + 0) % 4 : 4);
    data_i3 = draw_sample(corners ? (k + 3) % 4 : 4);
    data_q3 = draw_sample(corners ? (k + 2) % 4 : 4);
  endtask

  task automatic drain();
    next_cycle();
    next_cycle();
    while (exp_q.size() != 0 || mdl_strobe) begin
      next_cycle();
    end
    next_cycle();
  endtask

  initial begin
    int base_beats;
    int base_ovf;
    void'($urandom(32'hfd6f));
    err_cnt          = 0;
    cycle_cnt        = 0;
    mdl_drops        = 0;
    beats_seen       = 0;
    lasts_seen       = 0;
    ovf_seen         = 0;
    beats_since_last = 0;
    ready_mode       = 0;
    rst_n            = 1'b0;
    m_axis_tready    = 1'b0;
    valid_0          = 1'b0;
    valid_1          = 1'b0;
    valid_2          = 1'b0;
    valid_3          = 1'b0;
    data_i0          = '0;
    data_q0          = '0;
    data_i1          = '0;
    data_q1          = '0;
    data_i2          = '0;
    data_q2          = '0;
    data_i3          = '0;
    data_q3          = '0;
    repeat (5) next_cycle();
    rst_n = 1'b1;

    // quiet stream until the first strobe
    repeat (10) next_cycle();
    check_count("beats before first strobe", beats_seen, 0);

    // always ready, spaced strobes, corner values first
    for (int k = 0; k < P1_STROBES; k++) begin
      next_cycle();
      send_strobe(k < 4, k);
      repeat (P1_GAP - 1) next_cycle();
    end
    drain();
    check_count("beats", beats_seen, P1_STROBES);
    check_count("tlast beats", lasts_seen, P1_STROBES / BURST);
    check_count("overflow pulses", ovf_seen, 0);
    check_count("beats after the last tlast", beats_since_last, P1_STROBES % BURST);

    // random back-pressure
    base_beats = beats_seen;
    ready_mode = 1;
    for (int k = 0; k < P3_STROBES; k++) begin
      next_cycle();
      send_strobe(1'b0, k);
      repeat (P3_GAP - 1) next_cycle();
    end
    ready_mode = 0;
    drain();
    check_count("beats under random ready", beats_seen - base_beats, P3_STROBES - mdl_drops);
    check_count("overflow pulses", ovf_seen, mdl_drops);

    // sink stalled, first word held and the rest dropped
    base_beats = beats_seen;
    base_ovf   = ovf_seen;
    ready_mode = 2;
    next_cycle();
    for (int k = 0; k < P4_STROBES; k++) begin
      next_cycle();
      send_strobe(1'b0, k);
    end
    repeat (4) next_cycle();
    check_count("overflow pulses while stalled", ovf_seen - base_ovf, P4_STROBES - 1);
    ready_mode = 0;
    drain();
    check_count("beats after stall", beats_seen - base_beats, 1);
    check_count("tlast beats total", lasts_seen, beats_seen / BURST);

    if (err_cnt == 0) begin
      $display("test passed");
      $finish;
    end else begin
      $display("test failed");
      $fatal(1, "errors were recorded");
    end
  end

endmodule

// ==== sim/ad9361_axis_props.sv ====
//////////////////////////////////////////////////////////////////////
// stream protocol checks on the framer, attached by bind
// all checks sample on the rising edge of m_axis_clk
//////////////////////////////////////////////////////////////////////

module ad9361_axis_props
  import ad9361_axis_pkg::*;
(
  input logic       m_axis_clk,
  input logic       rst_n,
  input logic       word_strobe,
  input logic       m_axis_tready,
  input logic       m_axis_tvalid,
  input logic       m_axis_tlast,
  input axis_word_t m_axis_tdata,
  input logic       overflow
);

  // stalled beat keeps valid, payload and framing
  stall_holds_beat: assert property (
    @(posedge m_axis_clk) disable iff (!rst_n)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
  ) else $error("stream beat changed while stalled");

  // nothing leaves the framer in reset
  reset_quiet: assert property (
    @(posedge m_axis_clk)
    !rst_n |-> (!m_axis_tvalid && !overflow)
  ) else $error("tvalid or overflow high during reset");

  // a load into an empty register is never a drop
  no_ovf_on_fresh_load: assert property (
    @(posedge m_axis_clk) disable iff (!rst_n)
    (word_strobe && !m_axis_tvalid) |-> !overflow
  ) else $error("overflow alongside a load into an empty register");

endmodule

bind ad9361_stream_framer ad9361_axis_props u_props (
  .m_axis_clk    (m_axis_clk),
  .rst_n         (rst_n),
  .word_strobe   (word_strobe),
  .m_axis_tready (m_axis_tready),
  .m_axis_tvalid (m_axis_tvalid),
  .m_axis_tlast  (m_axis_tlast),
  .m_axis_tdata  (m_axis_tdata),
  .overflow      (overflow)
);

// ==== hw/ad9361_dual_axis_top.sv ====
//////////////////////////////////////////////////////////////////////
// AD9361 dual-channel raw samples to 128-bit AXI-stream
// single clock domain, two cycles from strobe to tvalid
// the stream sink must keep up with the strobe rate or words drop
//////////////////////////////////////////////////////////////////////

`include "ad9361_axis_consts.svh"

module ad9361_dual_axis_top
  import ad9361_axis_pkg::*;
#(
  parameter int PRECISION    = `AD_PRECISION_DEF,
  parameter int REVERSE_DATA = 0,
  parameter int BURST_LEN    = `AD_BURST_LEN_DEF
) (
  input  logic        m_axis_clk,
  input  logic        rst_n,

  // converter side
  input  logic        valid_0,
  input  logic        valid_1,
  input  logic        valid_2,
  input  logic        valid_3,
  input  raw_sample_t data_i0,
  input  raw_sample_t data_q0,
  input  raw_sample_t data_i1,
  input  raw_sample_t data_q1,
  input  raw_sample_t data_i2,
  input  raw_sample_t data_q2,
  input  raw_sample_t data_i3,
  input  raw_sample_t data_q3,

  // stream master
  input  logic        m_axis_tready,
  output logic        m_axis_tvalid,
  output logic        m_axis_tlast,
  output axis_word_t  m_axis_tdata,
  output logic        overflow
);

  logic       word_strobe;
  axis_word_t word_data;

  ad9361_sample_packer #(
    .PRECISION    (PRECISION),
    .REVERSE_DATA (REVERSE_DATA)
  ) u_packer (
    .m_axis_clk  (m_axis_clk),
    .rst_n       (rst_n),
    .valid_0     (valid_0),
    .valid_1     (valid_1),
    .valid_2     (valid_2),
    .valid_3     (valid_3),
    .data_i0     (data_i0),
    .data_q0     (data_q0),
    .data_i1     (data_i1),
    .data_q1     (data_q1),
    .data_i2     (data_i2),
    .data_q2     (data_q2),
    .data_i3     (data_i3),
    .data_q3     (data_q3),
    .word_strobe (word_strobe),
    .word_data   (word_data)
  );

  ad9361_stream_framer #(
    .BURST_LEN (BURST_LEN)
  ) u_framer (
    .m_axis_clk    (m_axis_clk),
    .rst_n         (rst_n),
    .word_strobe   (word_strobe),
    .word_data     (word_data),
    .m_axis_tready (m_axis_tready),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tlast  (m_axis_tlast),
    .m_axis_tdata  (m_axis_tdata),
    .overflow      (overflow)
  );

endmodule

// ==== hw/ad9361_stream_framer.sv ====
//////////////////////////////////////////////////////////////////////
// one-word stream stage with burst framing
// a word that arrives while the held word is stalled is dropped
// and flagged by overflow, never written over the held word
// tlast marks every BURST_LEN-th transferred beat
//////////////////////////////////////////////////////////////////////

`include "ad9361_axis_consts.svh"

module ad9361_stream_framer
  import ad9361_axis_pkg::*;
#(
  parameter int BURST_LEN = `AD_BURST_LEN_DEF
) (
  input  logic       m_axis_clk,
  input  logic       rst_n,

  // packed words from the capture stage
  input  logic       word_strobe,
  input  axis_word_t word_data,

  // stream master
  input  logic       m_axis_tready,
  output logic       m_axis_tvalid,
  output logic       m_axis_tlast,
  output axis_word_t m_axis_tdata,

  // one-cycle pulse per dropped word
  output logic       overflow
);

  // at least one counter bit, even for single-beat bursts
  localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(BURST_LEN - 1);

  logic             xfer;
  logic             stalled;
  logic             load;
  logic             drop;
  logic             end_burst;
  logic [CNT_W-1:0] beat_cnt;

  //////////////////////////////////////////////////////////////////////
  // handshake decode
  //////////////////////////////////////////////////////////////////////

  assign xfer    = m_axis_tvalid & m_axis_tready;
  assign stalled = m_axis_tvalid & ~m_axis_tready;

  // register is free when empty or draining this cycle
  assign load = word_strobe & ~stalled;
  assign drop = word_strobe & stalled;

  //////////////////////////////////////////////////////////////////////
  // holding register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      m_axis_tvalid <= 1'b0;
    end else if (load) begin
      m_axis_tvalid <= 1'b1;
    end else if (xfer) begin
      m_axis_tvalid <= 1'b0;
    end
  end

  // data only moves on a load, so it holds while stalled
  always_ff @(posedge m_axis_clk) begin
    if (load) begin
      m_axis_tdata <= word_data;
    end
  end

  // registered drop report
  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else begin
      overflow <= drop;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // burst framing
  //////////////////////////////////////////////////////////////////////

  assign end_burst = (beat_cnt == LAST_CNT);

  // counts transfers only, wraps on the last beat of a burst
  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      beat_cnt <= '0;
    end else if (xfer) begin
      if (end_burst) begin
        beat_cnt <= '0;
      end else begin
        beat_cnt <= beat_cnt + 1'b1;
      end
    end
  end

  // counter is frozen while stalled, so tlast is too
  assign m_axis_tlast = m_axis_tvalid & end_burst;

endmodule

// ==== hw/ad9361_sample_packer.sv ====
//////////////////////////////////////////////////////////////////////
// capture stage, one packed word per receive strobe
// any valid_n high triggers a capture of all eight values, so the
// front end is expected to present every pair with the strobe
// PRECISION must lie between 1 and AD_RAW_WIDTH
//////////////////////////////////////////////////////////////////////

`include "ad9361_axis_consts.svh"

module ad9361_sample_packer
  import ad9361_axis_pkg::*;
#(
  parameter int PRECISION    = `AD_PRECISION_DEF,
  parameter int REVERSE_DATA = 0
) (
  input  logic        m_axis_clk,
  input  logic        rst_n,

  input  logic        valid_0,
  input  logic        valid_1,
  input  logic        valid_2,
  input  logic        valid_3,
  input  raw_sample_t data_i0,
  input  raw_sample_t data_q0,
  input  raw_sample_t data_i1,
  input  raw_sample_t data_q1,
  input  raw_sample_t data_i2,
  input  raw_sample_t data_q2,
  input  raw_sample_t data_i3,
  input  raw_sample_t data_q3,

  output logic        word_strobe,
  output axis_word_t  word_data
);

  // two lanes per pair
  localparam int NUM_LANES = 2 * `AD_NUM_PAIRS;
  localparam int LANE_W    = `AD_LANE_WIDTH;
  // low bits dropped from each raw value
  localparam int SHIFT     = `AD_RAW_WIDTH - PRECISION;

  logic        capture;
  raw_sample_t samp [NUM_LANES];
  axis_word_t  packed_next;

  //////////////////////////////////////////////////////////////////////
  // precision reduction
  //////////////////////////////////////////////////////////////////////

  // keep the top PRECISION bits, then sign-extend into a lane
  function automatic lane_t reduce_lane(input raw_sample_t raw);
    raw_sample_t                 shifted;
    logic signed [PRECISION-1:0] kept;
    shifted = raw >>> SHIFT;
    kept    = shifted[PRECISION-1:0];
    return lane_t'(kept);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // capture event and lane ordering
  //////////////////////////////////////////////////////////////////////

  // one event no matter which channel strobed
  assign capture = valid_0 | valid_1 | valid_2 | valid_3;

  // natural order, q3 in lane 0 up to i0 in lane 7
  always_comb begin
    samp[0] = data_q3;
    samp[1] = data_i3;
    samp[2] = data_q2;
    samp[3] = data_i2;
    samp[4] = data_q1;
    samp[5] = data_i1;
    samp[6] = data_q0;
    samp[7] = data_i0;
  end

  // mirrored order puts i0 in lane 0
  always_comb begin
    packed_next = '0;
    for (int n = 0; n < NUM_LANES; n++) begin
      if (REVERSE_DATA != 0) begin
        packed_next[n*LANE_W +: LANE_W] = reduce_lane(samp[NUM_LANES-1-n]);
      end else begin
        packed_next[n*LANE_W +: LANE_W] = reduce_lane(samp[n]);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  // strobe lines up with the word it announces
  always_ff @(posedge m_axis_clk or negedge rst_n) begin
    if (!rst_n) begin
      word_strobe <= 1'b0;
    end else begin
      word_strobe <= capture;
    end
  end

  // payload, only updated on a capture
  always_ff @(posedge m_axis_clk) begin
    if (capture) begin
      word_data <= packed_next;
    end
  end

endmodule

// ==== hw/ad9361_axis_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// shared types of the sample packing path
// all widths come from the consts header
//////////////////////////////////////////////////////////////////////

`include "ad9361_axis_consts.svh"

package ad9361_axis_pkg;

  //////////////////////////////////////////////////////////////////////
  // converter side
  //////////////////////////////////////////////////////////////////////

  // one I or Q value straight from the converter
  typedef logic signed [`AD_RAW_WIDTH-1:0] raw_sample_t;

  //////////////////////////////////////////////////////////////////////
  // stream side
  //////////////////////////////////////////////////////////////////////

  // one sign-extended lane of the packed word
  typedef logic signed [`AD_LANE_WIDTH-1:0] lane_t;

  // full stream word, lane 0 in the low bits
  typedef logic [`AD_AXIS_WIDTH-1:0] axis_word_t;

endpackage

// ==== hw/ad9361_axis_consts.svh ====
//////////////////////////////////////////////////////////////////////
// widths and defaults for the AD9361 raw-to-AXI-stream path
// the stream width must equal two lanes per I/Q pair times the
// lane width, and the raw width must not exceed the lane width
//////////////////////////////////////////////////////////////////////

`ifndef AD9361_AXIS_CONSTS_SVH
`define AD9361_AXIS_CONSTS_SVH

// I/Q pairs delivered with each receive strobe
`define AD_NUM_PAIRS 4

// raw converter width, two's complement
`define AD_RAW_WIDTH 12

// one output lane
`define AD_LANE_WIDTH 16

// 8 lanes of 16 bits
`define AD_AXIS_WIDTH 128

// kept precision, 1 up to AD_RAW_WIDTH
`define AD_PRECISION_DEF 12

// beats between two tlast markers
`define AD_BURST_LEN_DEF 16

`endif
